// ==== design/alu_consts.svh ====
// sizes are fixed for the whole slice; PR_COUNT and PRF_BANK_COUNT must be powers of two
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// physical register file
`define PR_COUNT        32
`define PRF_BANK_COUNT  2

// back end sizing
`define ROB_ENTRIES     16
`define IQ_ENTRIES      4

// datapath
`define DATA_WIDTH      32

`endif

// ==== design/core_types_pkg.sv ====
// widths follow alu_consts.svh; a tag's bank is its low bit, the rest is the upper tag
`include "alu_consts.svh"

package core_types_pkg;

    // physical register tag and its bank split
    typedef logic [$clog2(`PR_COUNT)-1:0] pr_t;
    typedef logic [$clog2(`PRF_BANK_COUNT)-1:0] bank_t;
    typedef logic [$clog2(`PR_COUNT)-$clog2(`PRF_BANK_COUNT)-1:0] upper_pr_t;

    // ROB position carried along for writeback
    typedef logic [$clog2(`ROB_ENTRIES)-1:0] rob_index_t;

    // data word
    typedef logic [`DATA_WIDTH-1:0] word_t;

endpackage

// ==== design/alu_types_pkg.sv ====
// op codes above SLTU are undefined and produce a zero result
`include "alu_consts.svh"

package alu_types_pkg;

    // register-register ALU ops, shifts take B[4:0]
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLL  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        SLT  = 4'd8,
        SLTU = 4'd9
    } alu_op_t;

    // issue queue slot
    typedef logic [$clog2(`IQ_ENTRIES)-1:0] iq_slot_t;

endpackage

// ==== design/alu_reg_iq.sv ====
// one dispatch and one issue per cycle; issue only while pipeline_ready, no flush
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_reg_iq (
    input  logic                          CLK,
    input  logic                          nRST,

    // dispatch
    input  logic                          dispatch_valid,
    input  alu_types_pkg::alu_op_t        dispatch_op,
    input  core_types_pkg::pr_t           dispatch_a_pr,
    input  logic                          dispatch_a_ready,
    input  core_types_pkg::pr_t           dispatch_b_pr,
    input  logic                          dispatch_b_ready,
    input  core_types_pkg::pr_t           dispatch_dest_pr,
    input  core_types_pkg::rob_index_t    dispatch_rob_index,
    output logic                          dispatch_ready,

    input  logic                          pipeline_ready,

    // writeback bus wakeup
    input  logic [`PRF_BANK_COUNT-1:0]                        wb_bus_valid_by_bank,
    input  core_types_pkg::upper_pr_t [`PRF_BANK_COUNT-1:0]   wb_bus_upper_pr_by_bank,

    // issue to pipe
    output logic                          issue_valid,
    output alu_types_pkg::alu_op_t        issue_op,
    output logic                          issue_a_forward,
    output core_types_pkg::bank_t         issue_a_bank,
    output logic                          issue_b_forward,
    output core_types_pkg::bank_t         issue_b_bank,
    output core_types_pkg::pr_t           issue_dest_pr,
    output core_types_pkg::rob_index_t    issue_rob_index,

    // register file read requests
    output logic                          prf_req_a_valid,
    output core_types_pkg::pr_t           prf_req_a_pr,
    output logic                          prf_req_b_valid,
    output core_types_pkg::pr_t           prf_req_b_pr
);

    import core_types_pkg::*;
    import alu_types_pkg::*;

    // slot 0 holds the oldest entry
    logic [`IQ_ENTRIES-1:0] valid;
    logic [`IQ_ENTRIES-1:0] a_ready;
    logic [`IQ_ENTRIES-1:0] b_ready;
    alu_op_t                op        [`IQ_ENTRIES];
    pr_t                    a_pr      [`IQ_ENTRIES];
    pr_t                    b_pr      [`IQ_ENTRIES];
    pr_t                    dest_pr   [`IQ_ENTRIES];
    rob_index_t             rob_index [`IQ_ENTRIES];

    logic [`IQ_ENTRIES-1:0] a_fwd;
    logic [`IQ_ENTRIES-1:0] b_fwd;
    logic [`IQ_ENTRIES-1:0] entry_ready;
    logic [`IQ_ENTRIES-1:0] shift;
    logic [`IQ_ENTRIES-1:0] post_valid;
    logic [`IQ_ENTRIES-1:0] post_a_ready;
    logic [`IQ_ENTRIES-1:0] post_b_ready;
    logic [`IQ_ENTRIES-1:0] disp_we;
    logic                   disp_a_ready;
    logic                   disp_b_ready;
    iq_slot_t               issue_slot;

    function automatic logic bus_hit(
        input pr_t                                 pr,
        input logic [`PRF_BANK_COUNT-1:0]          bus_valid,
        input upper_pr_t [`PRF_BANK_COUNT-1:0]     bus_upper
    );
        bank_t bank;
        bank = bank_t'(pr);
        return bus_valid[bank] && (bus_upper[bank] == upper_pr_t'(pr >> $bits(bank_t)));
    endfunction

    //////////////////////////////////////////////////////////////////////
    // wakeup and oldest-first select

    always_comb begin
        for (int i = 0; i < `IQ_ENTRIES; i++) begin
            a_fwd[i] = bus_hit(a_pr[i], wb_bus_valid_by_bank, wb_bus_upper_pr_by_bank);
            b_fwd[i] = bus_hit(b_pr[i], wb_bus_valid_by_bank, wb_bus_upper_pr_by_bank);
        end
    end

    assign entry_ready = {`IQ_ENTRIES{pipeline_ready}} & valid
                       & (a_ready | a_fwd) & (b_ready | b_fwd);

    // scan down so the lowest ready slot wins
    always_comb begin
        issue_valid = 1'b0;
        issue_slot  = '0;
        for (int i = `IQ_ENTRIES-1; i >= 0; i--) begin
            if (entry_ready[i]) begin
                issue_valid = 1'b1;
                issue_slot  = iq_slot_t'(i);
            end
        end
    end

    assign issue_op        = op[issue_slot];
    assign issue_a_forward = a_fwd[issue_slot];
    assign issue_a_bank    = bank_t'(a_pr[issue_slot]);
    assign issue_b_forward = b_fwd[issue_slot];
    assign issue_b_bank    = bank_t'(b_pr[issue_slot]);
    assign issue_dest_pr   = dest_pr[issue_slot];
    assign issue_rob_index = rob_index[issue_slot];

    // forwarded operands skip the register file
    assign prf_req_a_valid = issue_valid & ~issue_a_forward;
    assign prf_req_a_pr    = a_pr[issue_slot];
    assign prf_req_b_valid = issue_valid & ~issue_b_forward;
    assign prf_req_b_pr    = b_pr[issue_slot];

    //////////////////////////////////////////////////////////////////////
    // compaction and dispatch placement

    always_comb begin
        for (int i = 0; i < `IQ_ENTRIES; i++) begin
            shift[i] = issue_valid && (iq_slot_t'(i) >= issue_slot);
        end
    end

    // slots at and above the issued one take the entry above
    assign post_valid   = (valid & ~shift) | ((valid >> 1) & shift);
    assign post_a_ready = ((a_ready | a_fwd) & ~shift) | (((a_ready | a_fwd) >> 1) & shift);
    assign post_b_ready = ((b_ready | b_fwd) & ~shift) | (((b_ready | b_fwd) >> 1) & shift);

    // entries stay contiguous, so the top slot tells if any is free
    assign dispatch_ready = ~post_valid[`IQ_ENTRIES-1];
    assign disp_we = ~post_valid & {post_valid[`IQ_ENTRIES-2:0], 1'b1}
                   & {`IQ_ENTRIES{dispatch_valid & dispatch_ready}};

    // a source written back at the dispatch edge would otherwise be missed
    assign disp_a_ready = dispatch_a_ready
                        | bus_hit(dispatch_a_pr, wb_bus_valid_by_bank, wb_bus_upper_pr_by_bank);
    assign disp_b_ready = dispatch_b_ready
                        | bus_hit(dispatch_b_pr, wb_bus_valid_by_bank, wb_bus_upper_pr_by_bank);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid   <= '0;
            a_ready <= '0;
            b_ready <= '0;
        end else begin
            valid   <= post_valid | disp_we;
            a_ready <= (post_a_ready & ~disp_we) | (disp_we & {`IQ_ENTRIES{disp_a_ready}});
            b_ready <= (post_b_ready & ~disp_we) | (disp_we & {`IQ_ENTRIES{disp_b_ready}});
        end
    end

    always_ff @(posedge CLK) begin
        for (int i = 0; i < `IQ_ENTRIES-1; i++) begin
            if (shift[i]) begin
                op[i]        <= op[i+1];
                a_pr[i]      <= a_pr[i+1];
                b_pr[i]      <= b_pr[i+1];
                dest_pr[i]   <= dest_pr[i+1];
                rob_index[i] <= rob_index[i+1];
            end
        end
        // dispatch lands after compaction
        for (int i = 0; i < `IQ_ENTRIES; i++) begin
            if (disp_we[i]) begin
                op[i]        <= dispatch_op;
                a_pr[i]      <= dispatch_a_pr;
                b_pr[i]      <= dispatch_b_pr;
                dest_pr[i]   <= dispatch_dest_pr;
                rob_index[i] <= dispatch_rob_index;
            end
        end
    end

endmodule

// ==== design/prf_banked.sv ====
// a load to the register the bus writes in the same cycle is dropped; reads see pre-edge values
`timescale 1ns/1ps
`include "alu_consts.svh"

module prf_banked (
    input  logic                          CLK,
    input  logic                          nRST,

    // read requests from the queue
    input  logic                          prf_req_a_valid,
    input  core_types_pkg::pr_t           prf_req_a_pr,
    input  logic                          prf_req_b_valid,
    input  core_types_pkg::pr_t           prf_req_b_pr,

    // registered read data
    output core_types_pkg::word_t         prf_rd_a_data,
    output core_types_pkg::word_t         prf_rd_b_data,

    // writeback bus
    input  logic [`PRF_BANK_COUNT-1:0]                        wb_bus_valid_by_bank,
    input  core_types_pkg::upper_pr_t [`PRF_BANK_COUNT-1:0]   wb_bus_upper_pr_by_bank,
    input  core_types_pkg::word_t         wb_bus_data,

    // external load port
    input  logic                          load_valid,
    input  core_types_pkg::pr_t           load_pr,
    input  core_types_pkg::word_t         load_data
);

    import core_types_pkg::*;

    word_t     mem [`PRF_BANK_COUNT][`PR_COUNT/`PRF_BANK_COUNT];

    bank_t     a_bank;
    upper_pr_t a_upper;
    bank_t     b_bank;
    upper_pr_t b_upper;
    bank_t     load_bank;
    upper_pr_t load_upper;

    assign {a_upper, a_bank}       = prf_req_a_pr;
    assign {b_upper, b_bank}       = prf_req_b_pr;
    assign {load_upper, load_bank} = load_pr;

    //////////////////////////////////////////////////////////////////////
    // write side

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
                for (int r = 0; r < `PR_COUNT/`PRF_BANK_COUNT; r++) begin
                    mem[b][r] <= '0;
                end
            end
        end else begin
            if (load_valid) begin
                mem[load_bank][load_upper] <= load_data;
            end
            // later assignment, so the bus wins a collision
            for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
                if (wb_bus_valid_by_bank[b]) begin
                    mem[b][wb_bus_upper_pr_by_bank[b]] <= wb_bus_data;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read side, held between requests

    always_ff @(posedge CLK) begin
        if (prf_req_a_valid) begin
            prf_rd_a_data <= mem[a_bank][a_upper];
        end
        if (prf_req_b_valid) begin
            prf_rd_b_data <= mem[b_bank][b_upper];
        end
    end

endmodule

// ==== design/alu_pipe.sv ====
// read stage plus writeback register; the bus is live only on a writeback transfer
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_pipe (
    input  logic                          CLK,
    input  logic                          nRST,

    // issue from the queue
    input  logic                          issue_valid,
    input  alu_types_pkg::alu_op_t        issue_op,
    input  logic                          issue_a_forward,
    input  core_types_pkg::bank_t         issue_a_bank,
    input  logic                          issue_b_forward,
    input  core_types_pkg::bank_t         issue_b_bank,
    input  core_types_pkg::pr_t           issue_dest_pr,
    input  core_types_pkg::rob_index_t    issue_rob_index,
    output logic                          pipeline_ready,

    // register file data, one cycle after request
    input  core_types_pkg::word_t         prf_rd_a_data,
    input  core_types_pkg::word_t         prf_rd_b_data,

    // writeback bus
    output logic [`PRF_BANK_COUNT-1:0]                        wb_bus_valid_by_bank,
    output core_types_pkg::upper_pr_t [`PRF_BANK_COUNT-1:0]   wb_bus_upper_pr_by_bank,
    output core_types_pkg::word_t         wb_bus_data,

    // writeback output
    output logic                          wb_valid,
    output core_types_pkg::pr_t           wb_pr,
    output core_types_pkg::word_t         wb_data,
    output core_types_pkg::rob_index_t    wb_rob_index,
    input  logic                          wb_ready
);

    import core_types_pkg::*;
    import alu_types_pkg::*;

    // read stage
    logic       rs_valid;
    alu_op_t    rs_op;
    logic       rs_a_forward;
    logic       rs_b_forward;
    word_t      rs_a_fwd_data;
    word_t      rs_b_fwd_data;
    pr_t        rs_dest_pr;
    rob_index_t rs_rob_index;

    logic       wb_free;
    word_t      op_a;
    word_t      op_b;
    word_t      result;

    assign wb_free        = ~wb_valid | wb_ready;
    assign pipeline_ready = ~rs_valid | wb_free;

    //////////////////////////////////////////////////////////////////////
    // read stage and execute

    always_ff @(posedge CLK) begin
        if (issue_valid) begin
            rs_op        <= issue_op;
            rs_dest_pr   <= issue_dest_pr;
            rs_rob_index <= issue_rob_index;
            // capture the bus word while it is still driven
            rs_a_forward  <= issue_a_forward & wb_bus_valid_by_bank[issue_a_bank];
            rs_b_forward  <= issue_b_forward & wb_bus_valid_by_bank[issue_b_bank];
            rs_a_fwd_data <= wb_bus_data;
            rs_b_fwd_data <= wb_bus_data;
        end
    end

    assign op_a = rs_a_forward ? rs_a_fwd_data : prf_rd_a_data;
    assign op_b = rs_b_forward ? rs_b_fwd_data : prf_rd_b_data;

    always_comb begin
        case (rs_op)
            ADD:     result = op_a + op_b;
            SUB:     result = op_a - op_b;
            AND:     result = op_a & op_b;
            OR:      result = op_a | op_b;
            XOR:     result = op_a ^ op_b;
            SLL:     result = op_a << op_b[4:0];
            SRL:     result = op_a >> op_b[4:0];
            SRA:     result = word_t'($signed(op_a) >>> op_b[4:0]);
            SLT:     result = word_t'($signed(op_a) < $signed(op_b));
            SLTU:    result = word_t'(op_a < op_b);
            default: result = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // writeback register and bus

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rs_valid <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            if (pipeline_ready) begin
                rs_valid <= issue_valid;
            end
            if (wb_free) begin
                wb_valid <= rs_valid;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (rs_valid && wb_free) begin
            wb_pr        <= rs_dest_pr;
            wb_data      <= result;
            wb_rob_index <= rs_rob_index;
        end
    end

    always_comb begin
        for (int i = 0; i < `PRF_BANK_COUNT; i++) begin
            wb_bus_valid_by_bank[i]    = wb_valid && wb_ready && (bank_t'(wb_pr) == bank_t'(i));
            wb_bus_upper_pr_by_bank[i] = upper_pr_t'(wb_pr >> $bits(bank_t));
        end
    end

    assign wb_bus_data = wb_data;

endmodule

// ==== design/alu_reg_top.sv ====
// single ALU slice; load port has no back-pressure and does not wake queue entries
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_reg_top (
    input  logic                          CLK,
    input  logic                          nRST,

    // dispatch
    input  logic                          dispatch_valid,
    input  alu_types_pkg::alu_op_t        dispatch_op,
    input  core_types_pkg::pr_t           dispatch_a_pr,
    input  logic                          dispatch_a_ready,
    input  core_types_pkg::pr_t           dispatch_b_pr,
    input  logic                          dispatch_b_ready,
    input  core_types_pkg::pr_t           dispatch_dest_pr,
    input  core_types_pkg::rob_index_t    dispatch_rob_index,
    output logic                          dispatch_ready,

    // load port
    input  logic                          load_valid,
    input  core_types_pkg::pr_t           load_pr,
    input  core_types_pkg::word_t         load_data,

    // writeback output
    output logic                          wb_valid,
    output core_types_pkg::pr_t           wb_pr,
    output core_types_pkg::word_t         wb_data,
    output core_types_pkg::rob_index_t    wb_rob_index,
    input  logic                          wb_ready
);

    import core_types_pkg::*;
    import alu_types_pkg::*;

    // queue to pipe
    logic       issue_valid;
    alu_op_t    issue_op;
    logic       issue_a_forward;
    bank_t      issue_a_bank;
    logic       issue_b_forward;
    bank_t      issue_b_bank;
    pr_t        issue_dest_pr;
    rob_index_t issue_rob_index;
    logic       pipeline_ready;

    // register file reads
    logic       prf_req_a_valid;
    pr_t        prf_req_a_pr;
    logic       prf_req_b_valid;
    pr_t        prf_req_b_pr;
    word_t      prf_rd_a_data;
    word_t      prf_rd_b_data;

    // writeback bus
    logic [`PRF_BANK_COUNT-1:0]      wb_bus_valid_by_bank;
    upper_pr_t [`PRF_BANK_COUNT-1:0] wb_bus_upper_pr_by_bank;
    word_t                           wb_bus_data;

    alu_reg_iq iq_i (.*);

    prf_banked prf_i (.*);

    alu_pipe pipe_i (.*);

endmodule

// ==== tb/alu_reg_properties.sv ====
// assumes valid is held until accepted; a load hitting the register the bus writes is illegal
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_reg_properties (
    input  logic                                            CLK,
    input  logic                                            nRST,
    input  logic                                            dispatch_valid,
    input  logic                                            dispatch_ready,
    input  alu_types_pkg::alu_op_t                          dispatch_op,
    input  core_types_pkg::pr_t                             dispatch_a_pr,
    input  logic                                            dispatch_a_ready,
    input  core_types_pkg::pr_t                             dispatch_b_pr,
    input  logic                                            dispatch_b_ready,
    input  core_types_pkg::pr_t                             dispatch_dest_pr,
    input  core_types_pkg::rob_index_t                      dispatch_rob_index,
    input  logic                                            wb_valid,
    input  logic                                            wb_ready,
    input  core_types_pkg::pr_t                             wb_pr,
    input  core_types_pkg::word_t                           wb_data,
    input  core_types_pkg::rob_index_t                      wb_rob_index,
    input  logic                                            issue_valid,
    input  logic                                            pipeline_ready,
    input  logic [`PRF_BANK_COUNT-1:0]                      wb_bus_valid_by_bank,
    input  core_types_pkg::upper_pr_t [`PRF_BANK_COUNT-1:0] wb_bus_upper_pr_by_bank,
    input  logic                                            load_valid,
    input  core_types_pkg::pr_t                             load_pr
);

    import core_types_pkg::*;

    logic load_hits_bus;

    assign load_hits_bus = load_valid && wb_bus_valid_by_bank[bank_t'(load_pr)]
        && (wb_bus_upper_pr_by_bank[bank_t'(load_pr)] == upper_pr_t'(load_pr >> $bits(bank_t)));

    dispatch_held: assert property (@(posedge CLK) disable iff (!nRST)
        dispatch_valid && !dispatch_ready |=> dispatch_valid
        && $stable({dispatch_op, dispatch_a_pr, dispatch_a_ready, dispatch_b_pr,
                    dispatch_b_ready, dispatch_dest_pr, dispatch_rob_index}))
        else $error("dispatch payload changed while stalled");

    wb_held: assert property (@(posedge CLK) disable iff (!nRST)
        wb_valid && !wb_ready |=> wb_valid && $stable({wb_pr, wb_data, wb_rob_index}))
        else $error("writeback payload changed while stalled");

    bus_onehot: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0(wb_bus_valid_by_bank))
        else $error("more than one writeback bus bank active");

    issue_gated: assert property (@(posedge CLK) disable iff (!nRST)
        !pipeline_ready |-> !issue_valid)
        else $error("issue while the pipeline is not ready");

    load_vs_bus: assert property (@(posedge CLK) disable iff (!nRST) !load_hits_bus)
        else $error("load and bus write to the same register in one cycle");

endmodule

bind alu_reg_top alu_reg_properties props_i (.*);

// ==== tb/alu_reg_tb.sv ====
// sources are loaded tags 0..7 or earlier destinations of the same batch; tags 8..17 are destinations
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_reg_tb;

    import core_types_pkg::*;
    import alu_types_pkg::*;

    localparam int RESET_CYCLES   = 8;
    localparam int LOAD_COUNT     = 8;
    localparam int DEST_BASE      = LOAD_COUNT;
    localparam int BATCH_OPS      = 10;
    localparam int FULL_OPS       = 6;
    // 10 + 10 + 4 x 10 + 6 operations over 7 batches
    localparam int OP_COUNT       = 66;
    localparam int BATCH_COUNT    = 7;
    localparam int CYCLES_PER_OP  = 6;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + OP_COUNT * CYCLES_PER_OP
                                  + BATCH_COUNT * (LOAD_COUNT + 10) + 10 + 200;

    logic       CLK;
    logic       nRST;
    logic       dispatch_valid;
    alu_op_t    dispatch_op;
    pr_t        dispatch_a_pr;
    logic       dispatch_a_ready;
    pr_t        dispatch_b_pr;
    logic       dispatch_b_ready;
    pr_t        dispatch_dest_pr;
    rob_index_t dispatch_rob_index;
    logic       dispatch_ready;
    logic       load_valid;
    pr_t        load_pr;
    word_t      load_data;
    logic       wb_valid;
    pr_t        wb_pr;
    word_t      wb_data;
    rob_index_t wb_rob_index;
    logic       wb_ready;

    // model state
    word_t      model_rf [`PR_COUNT];
    logic       written  [`PR_COUNT];
    word_t      exp_data [`ROB_ENTRIES];
    pr_t        exp_pr   [`ROB_ENTRIES];
    logic       pending  [`ROB_ENTRIES];
    int         outstanding;
    int         wb_count;
    int         next_rob_out;
    int         errors;
    int         checks;
    int         cycles;
    int         tests_run;
    int         tests_failed;
    int         errors_at_start;
    logic       in_order;
    logic       random_ready;
    word_t      lcg_state;

    alu_reg_top alu_reg_i (.*);

    initial begin
        CLK = 1'b0;
        forever begin
            #5 CLK = ~CLK;
        end
    end

    initial begin
        cycles = 0;
        while (cycles <= TIMEOUT_CYCLES) begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model and helpers

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t alu_ref(input alu_op_t op, input word_t a, input word_t b);
        int    sh;
        word_t fill;
        sh   = b[4:0];
        fill = {`DATA_WIDTH{a[`DATA_WIDTH-1]}};
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << sh;
            SRL:     return a >> sh;
            SRA:     return (a >> sh) | ((sh == 0) ? word_t'(0) : (fill << (`DATA_WIDTH - sh)));
            // signs differ, so the negative one is smaller
            SLT:     return (a[31] != b[31]) ? word_t'(a[31]) : word_t'(a < b);
            SLTU:    return word_t'(a < b);
            default: return '0;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
        errors++;
        $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, expected, actual);
    endtask

    task automatic next_cycle();
        word_t r;
        @(posedge CLK);
        #1;
        if (random_ready) begin
            r = lcg_next();
            wb_ready = r[20];
        end
    endtask

    task automatic load_sources();
        word_t r;
        for (int t = DEST_BASE; t < `PR_COUNT; t++) begin
            written[t] = 1'b0;
        end
        for (int t = 0; t < LOAD_COUNT; t++) begin
            r = lcg_next();
            load_valid  = 1'b1;
            load_pr     = pr_t'(t);
            load_data   = r;
            model_rf[t] = r;
            written[t]  = 1'b1;
            next_cycle();
        end
        load_valid   = 1'b0;
        wb_count     = 0;
        next_rob_out = 0;
    endtask

    // present only after a free slot was seen, so the transfer happens at the next edge
    task automatic send_op(input alu_op_t op, input pr_t a, input pr_t b, input pr_t dest,
                           input rob_index_t rob);
        logic free;
        free = 1'b0;
        while (!free) begin
            @(negedge CLK);
            free = dispatch_ready;
            next_cycle();
        end
        exp_data[rob]  = alu_ref(op, model_rf[a], model_rf[b]);
        exp_pr[rob]    = dest;
        model_rf[dest] = exp_data[rob];
        pending[rob]   = 1'b1;
        outstanding++;
        dispatch_valid     = 1'b1;
        dispatch_op        = op;
        dispatch_a_pr      = a;
        dispatch_a_ready   = written[a];
        dispatch_b_pr      = b;
        dispatch_b_ready   = written[b];
        dispatch_dest_pr   = dest;
        dispatch_rob_index = rob;
        @(negedge CLK);
        assert (dispatch_ready) else begin
            errors++;
            $display("dispatch of ROB index %0d was refused with a slot free", rob);
        end
        next_cycle();
        dispatch_valid = 1'b0;
    endtask

    task automatic drain_and_count(input int expected);
        while (outstanding != 0) begin
            next_cycle();
        end
        repeat (3) next_cycle();
        assert (wb_count == expected) else report_mismatch("writeback count", expected, wb_count);
    endtask

    // kind 0 all ops in order, kind 1 chains on the previous result, kind 2 random mix
    task automatic run_batch(input int kind);
        word_t   r;
        alu_op_t op;
        pr_t     a;
        pr_t     b;
        load_sources();
        for (int i = 0; i < BATCH_OPS; i++) begin
            r  = lcg_next();
            op = alu_op_t'(i);
            a  = pr_t'(r[2:0]);
            b  = pr_t'(r[5:3]);
            if (kind != 0) begin
                b = pr_t'((r >> 8) % (LOAD_COUNT + i));
            end
            if (kind == 1 && i > 0) begin
                a = pr_t'(DEST_BASE + i - 1);
            end
            if (kind == 2) begin
                op = alu_op_t'((r >> 16) % 10);
                a  = pr_t'((r >> 12) % (LOAD_COUNT + i));
            end
            send_op(op, a, b, pr_t'(DEST_BASE + i), rob_index_t'(i));
        end
        drain_and_count(BATCH_OPS);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors > errors_at_start) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_at_start);
        end else begin
            $display("test %s: passed", name);
        end
        errors_at_start = errors;
    endtask

    //////////////////////////////////////////////////////////////////////
    // writeback checker

    always @(negedge CLK) begin
        if (nRST && wb_valid && wb_ready) begin
            checks++;
            assert (pending[wb_rob_index]) else begin
                errors++;
                $display("writeback for ROB index %0d with no outstanding operation", wb_rob_index);
            end
            if (pending[wb_rob_index]) begin
                assert (wb_data == exp_data[wb_rob_index])
                    else report_mismatch("wb_data", exp_data[wb_rob_index], wb_data);
                assert (wb_pr == exp_pr[wb_rob_index])
                    else report_mismatch("wb_pr", word_t'(exp_pr[wb_rob_index]), word_t'(wb_pr));
                pending[wb_rob_index] = 1'b0;
                outstanding--;
            end
            if (in_order) begin
                assert (wb_rob_index == rob_index_t'(next_rob_out))
                    else report_mismatch("wb_rob_index", next_rob_out, word_t'(wb_rob_index));
                next_rob_out++;
            end
            written[wb_pr] = 1'b1;
            wb_count++;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        nRST = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_op = ADD;
        dispatch_a_pr = '0;
        dispatch_a_ready = 1'b0;
        dispatch_b_pr = '0;
        dispatch_b_ready = 1'b0;
        dispatch_dest_pr = '0;
        dispatch_rob_index = '0;
        load_valid = 1'b0;
        load_pr = '0;
        load_data = '0;
        wb_ready = 1'b1;
        lcg_state = 32'd6886;
        outstanding = 0;
        wb_count = 0;
        next_rob_out = 0;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        errors_at_start = 0;
        in_order = 1'b0;
        random_ready = 1'b0;
        for (int i = 0; i < `PR_COUNT; i++) begin
            model_rf[i] = '0;
            written[i]  = 1'b0;
        end
        for (int i = 0; i < `ROB_ENTRIES; i++) begin
            pending[i] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        nRST = 1'b1;

        @(negedge CLK);
        assert (!wb_valid) else report_mismatch("wb_valid", 0, word_t'(wb_valid));
        assert (dispatch_ready) else report_mismatch("dispatch_ready", 1, word_t'(dispatch_ready));
        next_cycle();
        finish_test("reset");

        in_order = 1'b1;
        run_batch(0);
        in_order = 1'b0;
        finish_test("independent operations");

        run_batch(1);
        finish_test("dependent chains");

        random_ready = 1'b1;
        repeat (4) run_batch(2);
        random_ready = 1'b0;
        wb_ready = 1'b1;
        finish_test("random back-pressure");

        // six fit: four queued, one in the read stage, one in writeback
        wb_ready = 1'b0;
        load_sources();
        for (int i = 0; i < FULL_OPS; i++) begin
            send_op(alu_op_t'(i), pr_t'(i), pr_t'(LOAD_COUNT - 1 - i), pr_t'(DEST_BASE + i),
                    rob_index_t'(i));
        end
        repeat (10) begin
            @(negedge CLK);
            assert (!dispatch_ready)
                else report_mismatch("dispatch_ready", 0, word_t'(dispatch_ready));
            next_cycle();
        end
        wb_ready = 1'b1;
        drain_and_count(FULL_OPS);
        finish_test("queue full");

        $display("tests %0d, failed %0d, writebacks checked %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+design
design/core_types_pkg.sv
design/alu_types_pkg.sv
design/alu_reg_iq.sv
design/prf_banked.sv
design/alu_pipe.sv
design/alu_reg_top.sv
tb/alu_reg_properties.sv
tb/alu_reg_tb.sv

// ==== Bender.yml ====
package:
  name: alu_reg_slice

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/core_types_pkg.sv
      - design/alu_types_pkg.sv
      - design/alu_reg_iq.sv
      - design/prf_banked.sv
      - design/alu_pipe.sv
      - design/alu_reg_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/alu_reg_properties.sv
      - tb/alu_reg_tb.sv
